//--- src.f
+incdir+include
rtl/dbg_pkg.sv
rtl/stack_trace_buf.sv
rtl/int_reg_bank.sv
rtl/csr_bank.sv
rtl/dbg_mem.sv
rtl/dbg_port.sv
rtl/dbg_core_top.sv
testbench/tb_dbg_core.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the debug port testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
    -f src.f --top-module tb_dbg_core -o tb_dbg_core
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

out=$(./obj_dir/tb_dbg_core)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q '^RESULT: PASS$'; then
    exit 0
fi
echo "Pass message not found"
exit 1

//--- testbench/tb_dbg_core.sv
`timescale 1ns/100ps

`include "dbg_defines.svh"

module tb_dbg_core;

localparam logic [31:0] SEED    = 32'h3238_d52d;
localparam int          N_REG   = 48;   // Random write/read pairs
localparam int          N_MEM   = 64;
localparam int          NUM_REQ = 2 * N_REG + N_MEM + 71;   // Directed requests add 71

typedef struct packed {
    logic                 skip;     // Read data unknown to the model
    dbg_pkg::dport_resp_t resp;
} exp_t;

logic                 i_clk = 1'b0;
logic                 i_nrst;
logic                 i_dport_req_valid;
dbg_pkg::dport_req_t  i_dport_req;
logic                 o_dport_req_ready;
logic                 o_dport_resp_valid;
dbg_pkg::dport_resp_t o_dport_resp;
logic                 i_dport_resp_ready = 1'b0;
logic                 i_e_call;
logic                 i_e_ret;
dbg_pkg::stk_entry_t  i_e_trace;

logic [`DBG_XLEN-1:0] sh_regs [0:31];
logic [`DBG_XLEN-1:0] sh_csr [0:`DBG_CSR_NUM-1];
logic [7:0]           sh_mem [0:`DBG_MEM_BYTES-1];
bit                   sh_mem_ok [0:`DBG_MEM_BYTES-1];
dbg_pkg::stk_entry_t  sh_stk [0:(1 << `DBG_STK_LOG2)-1];
bit                   sh_stk_ok [0:(1 << `DBG_STK_LOG2)-1];
int                   sh_cnt = 0;

exp_t                 exp_q [$];
int                   n_req = 0;
int                   n_resp = 0;
int                   value_errs = 0;
int                   other_errs = 0;
bit                   was_held = 1'b0;
dbg_pkg::dport_resp_t held_resp;

dbg_core_top dbg_core_top_inst (
    .i_clk              (i_clk),
    .i_nrst             (i_nrst),
    .i_dport_req_valid  (i_dport_req_valid),
    .i_dport_req        (i_dport_req),
    .o_dport_req_ready  (o_dport_req_ready),
    .o_dport_resp_valid (o_dport_resp_valid),
    .o_dport_resp       (o_dport_resp),
    .i_dport_resp_ready (i_dport_resp_ready),
    .i_e_call           (i_e_call),
    .i_e_ret            (i_e_ret),
    .i_e_trace          (i_e_trace)
);

always #2 i_clk = ~i_clk;

task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
        $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
        value_errs++;
    end
endtask

// Expected response of one request while updating the shadow state
function automatic exp_t model_response(input dbg_pkg::dport_req_t req);
    exp_t e;
    int   idx;
    int   nb;
    int   a;
    e   = '0;
    idx = int'(req.addr[11:0]);
    if (req.kind == dbg_pkg::DPORT_MEM) begin
        nb = 1 << req.size;
        a  = int'(req.addr);
        if ((a + nb > `DBG_MEM_BYTES) || ((a % nb) != 0)) begin
            e.resp.error = 1'b1;    // Refused by the memory
            e.resp.rdata = '1;
        end else begin
            for (int i = 0; i < nb; i++) begin
                if (req.write) begin
                    sh_mem[a + i]    = req.wdata[8*i +: 8];
                    sh_mem_ok[a + i] = 1'b1;
                end else begin
                    e.resp.rdata[8*i +: 8] = sh_mem[a + i];
                    if (!sh_mem_ok[a + i]) e.skip = 1'b1;
                end
            end
        end
    end else if (req.kind == dbg_pkg::DPORT_REG) begin
        case (req.addr[15:12])
        dbg_pkg::REGION_CSR: begin
            if (idx < `DBG_CSR_NUM) begin
                e.resp.rdata = sh_csr[idx];     // Old value, also on a write
                if (req.write) sh_csr[idx] = req.wdata;
            end else begin
                e.resp.error = 1'b1;
            end
        end
        dbg_pkg::REGION_REG: begin
            idx = int'(req.addr[5:0]);
            if ((idx >= 1) && (idx < 32)) begin
                e.resp.rdata = sh_regs[idx];
                if (req.write) sh_regs[idx] = req.wdata;
            end
        end
        dbg_pkg::REGION_EXT: begin
            if (idx == 64) begin
                e.resp.rdata = 64'(sh_cnt);
                if (req.write) sh_cnt = int'(req.wdata[`DBG_STK_LOG2-1:0]);
            end else if ((idx >= 128) && (idx < 144)) begin
                e.resp.rdata = (idx % 2 == 1) ? sh_stk[(idx - 128) / 2].npc
                                              : sh_stk[(idx - 128) / 2].pc;
                if (!sh_stk_ok[(idx - 128) / 2]) e.skip = 1'b1;
            end else begin
                e.resp.error = 1'b1;    // Unmapped extension index
            end
        end
        default: e.resp.error = 1'b1;
        endcase
    end else begin
        e.resp.error = 1'b1;
    end
    return e;
endfunction

task automatic send_request(input dbg_pkg::dport_kind_e kind, input logic wr,
                            input logic [15:0] addr, input logic [63:0] wdata,
                            input logic [1:0] size);
    dbg_pkg::dport_req_t req;
    req.kind  = kind;
    req.write = wr;
    req.addr  = addr;
    req.wdata = wdata;
    req.size  = size;
    exp_q.push_back(model_response(req));
    n_req++;
    @(negedge i_clk);
    i_dport_req_valid = 1'b1;
    i_dport_req       = req;
    while (!o_dport_req_ready) @(negedge i_clk);
    @(negedge i_clk);   // Taken at the edge in between
    i_dport_req_valid = 1'b0;
    i_dport_req       = '0;
    wait (n_resp == n_req);
endtask

task automatic trace_event(input logic call, input logic ret);
    dbg_pkg::stk_entry_t ent;
    ent.pc  = {$urandom, $urandom};
    ent.npc = {$urandom, $urandom};
    @(negedge i_clk);
    i_e_call  = call;
    i_e_ret   = ret;
    i_e_trace = ent;
    if (call && (sh_cnt != 7)) begin
        sh_stk[sh_cnt]    = ent;
        sh_stk_ok[sh_cnt] = 1'b1;
        sh_cnt++;
    end else if (ret && (sh_cnt != 0)) begin
        sh_cnt--;
    end
    @(negedge i_clk);
    i_e_call = 1'b0;
    i_e_ret  = 1'b0;
endtask

// Random back-pressure and response compare on the falling edge
always @(negedge i_clk) begin : compare
    exp_t e;
    logic take;
    if (!i_nrst) begin
        i_dport_resp_ready = 1'b0;
    end else begin
        take = ($urandom % 4) != 0;
        if (was_held) begin
            if (!o_dport_resp_valid) begin
                $display("Response valid dropped before the host accepted it");
                other_errs++;
            end
            check_value("o_dport_resp.error", {63'd0, o_dport_resp.error},
                        {63'd0, held_resp.error});
            check_value("o_dport_resp.rdata", o_dport_resp.rdata, held_resp.rdata);
        end
        if (o_dport_resp_valid && o_dport_req_ready) begin
            $display("Request ready is high while a response is pending");
            other_errs++;
        end
        was_held = o_dport_resp_valid && !take;
        held_resp = o_dport_resp;
        if (o_dport_resp_valid && take) begin
            if (exp_q.size() == 0) begin
                $display("Response arrived with no request outstanding");
                other_errs++;
            end else begin
                e = exp_q.pop_front();
                check_value("o_dport_resp.error", {63'd0, o_dport_resp.error},
                            {63'd0, e.resp.error});
                if (!e.skip) check_value("o_dport_resp.rdata", o_dport_resp.rdata, e.resp.rdata);
            end
            n_resp++;
        end
        i_dport_resp_ready = take;
    end
end

initial begin : watchdog
    repeat (NUM_REQ * 64 + 1000) @(posedge i_clk);
    $display("Timeout: the run did not finish within %0d cycles", NUM_REQ * 64 + 1000);
    $display("Errors: %0d value mismatches, %0d protocol errors", value_errs, other_errs);
    $display("RESULT: FAIL");
    $finish;
end

initial begin : stimulus
    logic [63:0] d;
    logic [15:0] a;
    logic [1:0]  sz;
    void'($urandom(SEED));
    i_nrst            = 1'b0;
    i_dport_req_valid = 1'b0;
    i_dport_req       = '0;
    i_e_call          = 1'b0;
    i_e_ret           = 1'b0;
    i_e_trace         = '0;
    for (int i = 0; i < 32; i++) sh_regs[i] = '0;
    for (int i = 0; i < `DBG_CSR_NUM; i++) sh_csr[i] = '0;
    repeat (8) @(posedge i_clk);
    @(negedge i_clk);
    i_nrst = 1'b1;
    @(negedge i_clk);
    check_value("o_dport_req_ready", {63'd0, o_dport_req_ready}, 64'd1);
    check_value("o_dport_resp_valid", {63'd0, o_dport_resp_valid}, 64'd0);

    // Register bank with x0 and indices 32..63 reading zero
    send_request(dbg_pkg::DPORT_REG, 1'b1, 16'h1000, {$urandom, $urandom}, 2'd3);
    send_request(dbg_pkg::DPORT_REG, 1'b0, 16'h1000, 64'd0, 2'd3);
    send_request(dbg_pkg::DPORT_REG, 1'b1, 16'h1028, {$urandom, $urandom}, 2'd3);
    send_request(dbg_pkg::DPORT_REG, 1'b0, 16'h1028, 64'd0, 2'd3);
    for (int i = 0; i < N_REG; i++) begin
        a = 16'h1000 | 16'($urandom % 64);
        send_request(dbg_pkg::DPORT_REG, 1'b1, a, {$urandom, $urandom}, 2'd3);
        a = 16'h1000 | 16'($urandom % 64);
        send_request(dbg_pkg::DPORT_REG, 1'b0, a, 64'd0, 2'd3);
    end

    // CSR accesses where addresses 8 and up raise the exception
    for (int i = 0; i < 10; i++) begin
        send_request(dbg_pkg::DPORT_REG, 1'b1, 16'(i), {$urandom, $urandom}, 2'd3);
    end
    for (int i = 0; i < 10; i++) begin
        send_request(dbg_pkg::DPORT_REG, 1'b0, 16'(i), 64'd0, 2'd3);
    end
    send_request(dbg_pkg::DPORT_REG, 1'b0, 16'h0FFF, 64'd0, 2'd3);

    // Memory of every size and then partial bytes
    for (int s = 0; s < 4; s++) begin
        a  = 16'h0040 + 16'(s * 16);
        sz = 2'(s);
        send_request(dbg_pkg::DPORT_MEM, 1'b1, a, {$urandom, $urandom}, sz);
        send_request(dbg_pkg::DPORT_MEM, 1'b0, a, 64'd0, sz);
    end
    d = {$urandom, $urandom};
    send_request(dbg_pkg::DPORT_MEM, 1'b1, 16'h0080, d, 2'd3);
    send_request(dbg_pkg::DPORT_MEM, 1'b1, 16'h0083, ~d, 2'd0);    // One byte overwritten
    send_request(dbg_pkg::DPORT_MEM, 1'b0, 16'h0080, 64'd0, 2'd3);
    send_request(dbg_pkg::DPORT_MEM, 1'b0, 16'h0086, 64'd0, 2'd1);
    send_request(dbg_pkg::DPORT_MEM, 1'b0, 16'h0084, 64'd0, 2'd2);
    for (int i = 0; i < N_MEM; i++) begin
        sz = 2'($urandom % 4);
        a  = 16'($urandom % 192) & ~((16'd1 << sz) - 16'd1);
        send_request(dbg_pkg::DPORT_MEM, 1'($urandom % 2), a, {$urandom, $urandom}, sz);
    end
    send_request(dbg_pkg::DPORT_MEM, 1'b0, 16'h0400, 64'd0, 2'd0);    // Past the end
    send_request(dbg_pkg::DPORT_MEM, 1'b1, 16'hFFF8, d, 2'd3);
    send_request(dbg_pkg::DPORT_MEM, 1'b0, 16'h0003, 64'd0, 2'd2);    // Misaligned
    send_request(dbg_pkg::DPORT_MEM, 1'b1, 16'h0001, d, 2'd1);

    // Stack trace saturating at 7 entries
    for (int i = 0; i < 10; i++) trace_event(1'b1, 1'b0);
    send_request(dbg_pkg::DPORT_REG, 1'b0, 16'hC040, 64'd0, 2'd3);
    for (int i = 128; i < 144; i++) begin
        send_request(dbg_pkg::DPORT_REG, 1'b0, 16'hC000 | 16'(i), 64'd0, 2'd3);
    end
    trace_event(1'b1, 1'b1);    // Full so the RET pops
    send_request(dbg_pkg::DPORT_REG, 1'b0, 16'hC040, 64'd0, 2'd3);
    for (int i = 0; i < 8; i++) trace_event(1'b0, 1'b1);   // Last RETs find it empty
    send_request(dbg_pkg::DPORT_REG, 1'b0, 16'hC040, 64'd0, 2'd3);
    send_request(dbg_pkg::DPORT_REG, 1'b1, 16'hC040, 64'd5, 2'd3);
    trace_event(1'b1, 1'b0);
    send_request(dbg_pkg::DPORT_REG, 1'b0, 16'hC040, 64'd0, 2'd3);
    send_request(dbg_pkg::DPORT_REG, 1'b0, 16'hC08A, 64'd0, 2'd3);
    send_request(dbg_pkg::DPORT_REG, 1'b0, 16'hC08B, 64'd0, 2'd3);

    // Decode errors
    send_request(dbg_pkg::DPORT_INVALID, 1'b0, 16'h1001, 64'd0, 2'd3);
    send_request(dbg_pkg::dport_kind_e'(2'd3), 1'b0, 16'h1001, 64'd0, 2'd3);
    send_request(dbg_pkg::DPORT_REG, 1'b0, 16'h5000, 64'd0, 2'd3);    // Unknown region
    send_request(dbg_pkg::DPORT_REG, 1'b0, 16'hC010, 64'd0, 2'd3);
    send_request(dbg_pkg::DPORT_REG, 1'b1, 16'hC041, 64'd0, 2'd3);
    send_request(dbg_pkg::DPORT_REG, 1'b0, 16'hC090, 64'd0, 2'd3);

    repeat (4) @(negedge i_clk);
    if (exp_q.size() != 0) begin
        $display("%0d expected responses never arrived", exp_q.size());
        other_errs++;
    end
    $display("Errors: %0d value mismatches, %0d protocol errors", value_errs, other_errs);
    if ((value_errs + other_errs) == 0) begin
        $display("RESULT: PASS");
    end else begin
        $display("RESULT: FAIL");
    end
    $finish;
end

endmodule

//--- rtl/dbg_core_top.sv
`timescale 1ns/100ps

`include "dbg_defines.svh"

module dbg_core_top (
    input  logic                 i_clk,
    input  logic                 i_nrst,
    input  logic                 i_dport_req_valid,
    input  dbg_pkg::dport_req_t  i_dport_req,
    output logic                 o_dport_req_ready,
    output logic                 o_dport_resp_valid,
    output dbg_pkg::dport_resp_t o_dport_resp,
    input  logic                 i_dport_resp_ready,
    input  logic                 i_e_call,
    input  logic                 i_e_ret,
    input  dbg_pkg::stk_entry_t  i_e_trace
);

logic                     csr_req_valid;
dbg_pkg::csr_req_t        csr_req;
logic                     csr_req_ready;
logic                     csr_resp_valid;
dbg_pkg::csr_resp_t       csr_resp;
logic                     csr_resp_ready;
dbg_pkg::ireg_req_t       ireg;
logic [`DBG_XLEN-1:0]     ireg_rdata;
logic                     mem_req_valid;
dbg_pkg::mem_req_t        mem_req;
logic                     mem_req_ready;
logic                     mem_req_error;
logic                     mem_resp_valid;
dbg_pkg::mem_resp_t       mem_resp;
logic                     stk_we;
logic [`DBG_STK_LOG2-1:0] stk_waddr;
dbg_pkg::stk_entry_t      stk_wdata;
logic [`DBG_STK_LOG2-1:0] stk_raddr;
dbg_pkg::stk_entry_t      stk_rdata;

dbg_port dbg_port_inst (
    .i_clk              (i_clk),
    .i_nrst             (i_nrst),
    .i_dport_req_valid  (i_dport_req_valid),
    .i_dport_req        (i_dport_req),
    .o_dport_req_ready  (o_dport_req_ready),
    .o_dport_resp_valid (o_dport_resp_valid),
    .o_dport_resp       (o_dport_resp),
    .i_dport_resp_ready (i_dport_resp_ready),
    .o_csr_req_valid    (csr_req_valid),
    .o_csr_req          (csr_req),
    .i_csr_req_ready    (csr_req_ready),
    .i_csr_resp_valid   (csr_resp_valid),
    .i_csr_resp         (csr_resp),
    .o_csr_resp_ready   (csr_resp_ready),
    .o_ireg             (ireg),
    .i_ireg_rdata       (ireg_rdata),
    .o_mem_req_valid    (mem_req_valid),
    .o_mem_req          (mem_req),
    .i_mem_req_ready    (mem_req_ready),
    .i_mem_req_error    (mem_req_error),
    .i_mem_resp_valid   (mem_resp_valid),
    .i_mem_resp         (mem_resp),
    .i_e_call           (i_e_call),
    .i_e_ret            (i_e_ret),
    .i_e_trace          (i_e_trace),
    .o_stk_we           (stk_we),
    .o_stk_waddr        (stk_waddr),
    .o_stk_wdata        (stk_wdata),
    .o_stk_raddr        (stk_raddr),
    .i_stk_rdata        (stk_rdata)
);

stack_trace_buf stack_trace_buf_inst (
    .i_clk   (i_clk),
    .i_we    (stk_we),
    .i_waddr (stk_waddr),
    .i_wdata (stk_wdata),
    .i_raddr (stk_raddr),
    .o_rdata (stk_rdata)
);

int_reg_bank int_reg_bank_inst (
    .i_clk   (i_clk),
    .i_nrst  (i_nrst),
    .i_ireg  (ireg),
    .o_rdata (ireg_rdata)
);

csr_bank csr_bank_inst (
    .i_clk        (i_clk),
    .i_nrst       (i_nrst),
    .i_req_valid  (csr_req_valid),
    .i_req        (csr_req),
    .o_req_ready  (csr_req_ready),
    .o_resp_valid (csr_resp_valid),
    .o_resp       (csr_resp),
    .i_resp_ready (csr_resp_ready)
);

dbg_mem dbg_mem_inst (
    .i_clk        (i_clk),
    .i_nrst       (i_nrst),
    .i_req_valid  (mem_req_valid),
    .i_req        (mem_req),
    .o_req_ready  (mem_req_ready),
    .o_req_error  (mem_req_error),
    .o_resp_valid (mem_resp_valid),
    .o_resp       (mem_resp)
);

endmodule

//--- rtl/dbg_port.sv
`timescale 1ns/100ps

`include "dbg_defines.svh"

module dbg_port (
    input  logic                     i_clk,
    input  logic                     i_nrst,
    input  logic                     i_dport_req_valid,
    input  dbg_pkg::dport_req_t      i_dport_req,
    output logic                     o_dport_req_ready,
    output logic                     o_dport_resp_valid,
    output dbg_pkg::dport_resp_t     o_dport_resp,
    input  logic                     i_dport_resp_ready,
    output logic                     o_csr_req_valid,
    output dbg_pkg::csr_req_t        o_csr_req,
    input  logic                     i_csr_req_ready,
    input  logic                     i_csr_resp_valid,
    input  dbg_pkg::csr_resp_t       i_csr_resp,
    output logic                     o_csr_resp_ready,
    output dbg_pkg::ireg_req_t       o_ireg,
    input  logic [`DBG_XLEN-1:0]     i_ireg_rdata,
    output logic                     o_mem_req_valid,
    output dbg_pkg::mem_req_t        o_mem_req,
    input  logic                     i_mem_req_ready,
    input  logic                     i_mem_req_error,
    input  logic                     i_mem_resp_valid,
    input  dbg_pkg::mem_resp_t       i_mem_resp,
    input  logic                     i_e_call,
    input  logic                     i_e_ret,
    input  dbg_pkg::stk_entry_t      i_e_trace,
    output logic                     o_stk_we,
    output logic [`DBG_STK_LOG2-1:0] o_stk_waddr,
    output dbg_pkg::stk_entry_t      o_stk_wdata,
    output logic [`DBG_STK_LOG2-1:0] o_stk_raddr,
    input  dbg_pkg::stk_entry_t      i_stk_rdata
);

localparam logic [11:0] IDX_STK_CNT  = 12'd64;
localparam logic [11:0] IDX_STK_BASE = 12'd128;
localparam logic [11:0] IDX_STK_END  = IDX_STK_BASE + 12'(2 << `DBG_STK_LOG2);

dbg_pkg::dport_state_e    state_q, state_d;
dbg_pkg::dport_req_t      req_q, req_d;
logic [`DBG_XLEN-1:0]     rdata_q, rdata_d;
logic                     err_q, err_d;
logic                     csr_acc_q, csr_acc_d;     // CSR request accepted
logic [`DBG_STK_LOG2-1:0] stk_cnt_q, stk_cnt_d;
logic [11:0]              idx;

always_comb begin
    state_d   = state_q;
    req_d     = req_q;
    rdata_d   = rdata_q;
    err_d     = err_q;
    csr_acc_d = csr_acc_q;
    stk_cnt_d = stk_cnt_q;
    idx       = i_dport_req.addr[11:0];

    o_dport_req_ready  = 1'b0;
    o_dport_resp_valid = 1'b0;
    o_csr_req_valid    = 1'b0;
    o_csr_resp_ready   = 1'b0;
    o_mem_req_valid    = 1'b0;
    o_ireg             = '0;
    o_stk_raddr        = '0;
    o_stk_we           = 1'b0;
    o_stk_waddr        = stk_cnt_q;
    o_stk_wdata        = i_e_trace;

    // Trace push on CALL, pop on RET, CALL first
    if (i_e_call && (stk_cnt_q != '1)) begin
        o_stk_we  = 1'b1;
        stk_cnt_d = stk_cnt_q + 1'b1;
    end else if (i_e_ret && (stk_cnt_q != '0)) begin
        stk_cnt_d = stk_cnt_q - 1'b1;
    end

    case (state_q)
    dbg_pkg::ST_IDLE: begin
        o_dport_req_ready = 1'b1;
        rdata_d   = '0;
        err_d     = 1'b0;
        csr_acc_d = 1'b0;
        if (i_dport_req_valid) begin
            req_d   = i_dport_req;
            state_d = dbg_pkg::ST_WAIT_ACCEPT;  // Error answer unless decoded below
            err_d   = 1'b1;
            if (i_dport_req.kind == dbg_pkg::DPORT_REG) begin
                case (i_dport_req.addr[15:12])
                dbg_pkg::REGION_CSR: begin
                    state_d = dbg_pkg::ST_CSR_REGION;
                    err_d   = 1'b0;
                end
                dbg_pkg::REGION_REG: begin
                    state_d = dbg_pkg::ST_REG_BANK;
                    err_d   = 1'b0;
                end
                dbg_pkg::REGION_EXT: begin
                    if (idx == IDX_STK_CNT) begin
                        state_d = dbg_pkg::ST_STK_CNT;
                        err_d   = 1'b0;
                    end else if ((idx >= IDX_STK_BASE) && (idx < IDX_STK_END)) begin
                        state_d = dbg_pkg::ST_STK_ADR;
                        err_d   = 1'b0;
                    end
                end
                default: begin
                end
                endcase
            end else if (i_dport_req.kind == dbg_pkg::DPORT_MEM) begin
                state_d = dbg_pkg::ST_MEM_REQUEST;
                err_d   = 1'b0;
            end
        end
    end
    dbg_pkg::ST_CSR_REGION: begin
        o_csr_req_valid  = !csr_acc_q;
        o_csr_resp_ready = csr_acc_q;
        if (!csr_acc_q && i_csr_req_ready) begin
            csr_acc_d = 1'b1;
        end
        if (csr_acc_q && i_csr_resp_valid) begin
            rdata_d = i_csr_resp.data;
            err_d   = i_csr_resp.exception;
            state_d = dbg_pkg::ST_WAIT_ACCEPT;
        end
    end
    dbg_pkg::ST_REG_BANK: begin
        o_ireg.en    = 1'b1;
        o_ireg.write = req_q.write;
        o_ireg.addr  = req_q.addr[5:0];
        o_ireg.wdata = req_q.wdata;
        rdata_d      = i_ireg_rdata;    // Value before the write
        state_d      = dbg_pkg::ST_WAIT_ACCEPT;
    end
    dbg_pkg::ST_STK_CNT: begin
        rdata_d = '0;
        rdata_d[`DBG_STK_LOG2-1:0] = stk_cnt_q;
        if (req_q.write) begin
            stk_cnt_d = req_q.wdata[`DBG_STK_LOG2-1:0]; // Host overrides CALL/RET
        end
        state_d = dbg_pkg::ST_WAIT_ACCEPT;
    end
    dbg_pkg::ST_STK_ADR: begin
        o_stk_raddr = req_q.addr[`DBG_STK_LOG2:1];   // Entry k of 128+2k+b
        state_d     = dbg_pkg::ST_STK_DAT;
    end
    dbg_pkg::ST_STK_DAT: begin
        rdata_d = req_q.addr[0] ? i_stk_rdata.npc : i_stk_rdata.pc;
        state_d = dbg_pkg::ST_WAIT_ACCEPT;
    end
    dbg_pkg::ST_MEM_REQUEST: begin
        o_mem_req_valid = 1'b1;
        if (i_mem_req_ready) begin
            if (i_mem_req_error) begin
                err_d   = 1'b1;
                rdata_d = '1;
                state_d = dbg_pkg::ST_WAIT_ACCEPT;
            end else begin
                state_d = dbg_pkg::ST_MEM_RESPONSE;
            end
        end
    end
    dbg_pkg::ST_MEM_RESPONSE: begin
        if (i_mem_resp_valid) begin
            rdata_d = i_mem_resp.rdata;
            err_d   = i_mem_resp.error;
            state_d = dbg_pkg::ST_WAIT_ACCEPT;
        end
    end
    dbg_pkg::ST_WAIT_ACCEPT: begin
        o_dport_resp_valid = 1'b1;      // Held until host takes it
        if (i_dport_resp_ready) begin
            state_d = dbg_pkg::ST_IDLE;
        end
    end
    default: begin
        state_d = dbg_pkg::ST_IDLE;
    end
    endcase
end

always_comb begin
    o_dport_resp.error = err_q;
    o_dport_resp.rdata = rdata_q;
    o_csr_req.write    = req_q.write;
    o_csr_req.addr     = req_q.addr[11:0];
    o_csr_req.data     = req_q.wdata;
    o_mem_req.write    = req_q.write;
    o_mem_req.addr     = {{(`DBG_XLEN-16){1'b0}}, req_q.addr};
    o_mem_req.size     = req_q.size;
    o_mem_req.wdata    = req_q.wdata;
end

always_ff @(posedge i_clk or negedge i_nrst) begin
    if (!i_nrst) begin
        state_q   <= dbg_pkg::ST_IDLE;
        req_q     <= '0;
        rdata_q   <= '0;
        err_q     <= 1'b0;
        csr_acc_q <= 1'b0;
        stk_cnt_q <= '0;
    end else begin
        state_q   <= state_d;
        req_q     <= req_d;
        rdata_q   <= rdata_d;
        err_q     <= err_d;
        csr_acc_q <= csr_acc_d;
        stk_cnt_q <= stk_cnt_d;
    end
end

endmodule

//--- rtl/dbg_mem.sv
`timescale 1ns/100ps

`include "dbg_defines.svh"

module dbg_mem (
    input  logic               i_clk,
    input  logic               i_nrst,
    input  logic               i_req_valid,
    input  dbg_pkg::mem_req_t  i_req,
    output logic               o_req_ready,
    output logic               o_req_error,
    output logic               o_resp_valid,
    output dbg_pkg::mem_resp_t o_resp
);

localparam int                   AW       = $clog2(`DBG_MEM_BYTES);
localparam logic [`DBG_XLEN-1:0] MEM_TOP  = `DBG_MEM_BYTES;
localparam logic [7:0]           LAT_INIT = 8'(`DBG_MEM_LAT - 1);

logic [7:0]           mem [0:`DBG_MEM_BYTES-1];
logic                 busy_q;
logic [7:0]           lat_cnt_q;
logic [`DBG_XLEN-1:0] rdata_q;
logic [3:0]           nbytes;
logic [2:0]           align_mask;
logic [AW-1:0]        base;
logic                 bad;
logic                 accept;

always_comb begin
    nbytes     = 4'd1 << i_req.size;
    align_mask = 3'(nbytes - 4'd1);
    base       = i_req.addr[AW-1:0];
    bad        = (i_req.addr >= MEM_TOP) || ((i_req.addr[2:0] & align_mask) != 3'd0);
    accept     = i_req_valid && !busy_q;
end

assign o_req_ready  = !busy_q;
assign o_req_error  = accept && bad;    // Refused in the accept cycle
assign o_resp_valid = busy_q && (lat_cnt_q == 8'd0);
assign o_resp.error = 1'b0;
assign o_resp.rdata = rdata_q;

always_ff @(posedge i_clk or negedge i_nrst) begin
    if (!i_nrst) begin
        busy_q    <= 1'b0;
        lat_cnt_q <= '0;
    end else if (accept && !bad) begin
        busy_q    <= 1'b1;
        lat_cnt_q <= LAT_INIT;
    end else if (busy_q) begin
        if (lat_cnt_q == 8'd0) begin
            busy_q <= 1'b0;     // Response shown for one cycle
        end else begin
            lat_cnt_q <= lat_cnt_q - 8'd1;
        end
    end
end

// Little-endian byte lanes, reads zero-extended
always_ff @(posedge i_clk) begin
    if (accept && !bad) begin
        for (int i = 0; i < 8; i++) begin
            if (4'(i) < nbytes) begin
                if (i_req.write) begin
                    mem[base + AW'(i)] <= i_req.wdata[8*i +: 8];
                end
                rdata_q[8*i +: 8] <= i_req.write ? 8'd0 : mem[base + AW'(i)];
            end else begin
                rdata_q[8*i +: 8] <= 8'd0;
            end
        end
    end
end

endmodule

//--- rtl/csr_bank.sv
`timescale 1ns/100ps

`include "dbg_defines.svh"

module csr_bank (
    input  logic               i_clk,
    input  logic               i_nrst,
    input  logic               i_req_valid,
    input  dbg_pkg::csr_req_t  i_req,
    output logic               o_req_ready,
    output logic               o_resp_valid,
    output dbg_pkg::csr_resp_t o_resp,
    input  logic               i_resp_ready
);

localparam int CSR_AW = $clog2(`DBG_CSR_NUM);

logic [`DBG_XLEN-1:0] csr [0:`DBG_CSR_NUM-1];
logic                 resp_valid_q;
dbg_pkg::csr_resp_t   resp_q;
logic                 accept;
logic                 hit;

assign o_req_ready  = !resp_valid_q;    // One request at a time
assign accept       = i_req_valid && !resp_valid_q;
assign hit          = i_req.addr < 12'(`DBG_CSR_NUM);
assign o_resp_valid = resp_valid_q;
assign o_resp       = resp_q;

always_ff @(posedge i_clk or negedge i_nrst) begin
    if (!i_nrst) begin
        resp_valid_q <= 1'b0;
        for (int i = 0; i < `DBG_CSR_NUM; i++) begin
            csr[i] <= '0;
        end
    end else if (accept) begin
        resp_valid_q <= 1'b1;
        if (hit && i_req.write) begin
            csr[i_req.addr[CSR_AW-1:0]] <= i_req.data;
        end
    end else if (resp_valid_q && i_resp_ready) begin
        resp_valid_q <= 1'b0;
    end
end

always_ff @(posedge i_clk) begin
    if (accept) begin
        if (hit) begin
            resp_q.data      <= csr[i_req.addr[CSR_AW-1:0]];  // Old value on write
            resp_q.exception <= 1'b0;
        end else begin
            resp_q.data      <= '0;     // Unimplemented CSR
            resp_q.exception <= 1'b1;
        end
    end
end

endmodule

//--- rtl/int_reg_bank.sv
`timescale 1ns/100ps

`include "dbg_defines.svh"

module int_reg_bank (
    input  logic                 i_clk,
    input  logic                 i_nrst,
    input  dbg_pkg::ireg_req_t   i_ireg,
    output logic [`DBG_XLEN-1:0] o_rdata
);

logic [`DBG_XLEN-1:0] regs [1:31];
logic                 hit;      // Address maps to x1..x31

assign hit = !i_ireg.addr[5] && (i_ireg.addr[4:0] != 5'd0);

always_ff @(posedge i_clk or negedge i_nrst) begin
    if (!i_nrst) begin
        for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
        end
    end else if (i_ireg.en && i_ireg.write && hit) begin
        regs[i_ireg.addr[4:0]] <= i_ireg.wdata;
    end
end

// x0 and the upper half of the index space read as zero
assign o_rdata = hit ? regs[i_ireg.addr[4:0]] : '0;

endmodule

//--- rtl/stack_trace_buf.sv
`timescale 1ns/100ps

`include "dbg_defines.svh"

module stack_trace_buf (
    input  logic                     i_clk,
    input  logic                     i_we,
    input  logic [`DBG_STK_LOG2-1:0] i_waddr,
    input  dbg_pkg::stk_entry_t      i_wdata,
    input  logic [`DBG_STK_LOG2-1:0] i_raddr,
    output dbg_pkg::stk_entry_t      o_rdata
);

dbg_pkg::stk_entry_t mem [0:(1 << `DBG_STK_LOG2)-1];   // {npc, pc} pairs

always_ff @(posedge i_clk) begin
    if (i_we) begin
        mem[i_waddr] <= i_wdata;
    end
    o_rdata <= mem[i_raddr];    // Data one cycle after address
end

endmodule

//--- rtl/dbg_pkg.sv
`include "dbg_defines.svh"

package dbg_pkg;

    typedef enum logic [1:0] {
        DPORT_REG     = 2'd0,   // CSR, register bank or extension region
        DPORT_MEM     = 2'd1,
        DPORT_INVALID = 2'd2
    } dport_kind_e;

    typedef struct packed {
        dport_kind_e          kind;
        logic                 write;
        logic [15:0]          addr;     // Region in bits 15:12
        logic [`DBG_XLEN-1:0] wdata;
        logic [1:0]           size;     // 0 = 1 byte .. 3 = 8 bytes
    } dport_req_t;

    typedef struct packed {
        logic                 error;
        logic [`DBG_XLEN-1:0] rdata;
    } dport_resp_t;

    typedef struct packed {
        logic                 write;
        logic [11:0]          addr;
        logic [`DBG_XLEN-1:0] data;
    } csr_req_t;

    typedef struct packed {
        logic [`DBG_XLEN-1:0] data;
        logic                 exception;
    } csr_resp_t;

    typedef struct packed {
        logic                 write;
        logic [`DBG_XLEN-1:0] addr;
        logic [1:0]           size;
        logic [`DBG_XLEN-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                 error;
        logic [`DBG_XLEN-1:0] rdata;
    } mem_resp_t;

    typedef struct packed {
        logic                 en;
        logic                 write;
        logic [5:0]           addr;
        logic [`DBG_XLEN-1:0] wdata;
    } ireg_req_t;

    typedef struct packed {
        logic [`DBG_XLEN-1:0] npc;
        logic [`DBG_XLEN-1:0] pc;
    } stk_entry_t;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_CSR_REGION,
        ST_REG_BANK,
        ST_STK_CNT,
        ST_STK_ADR,
        ST_STK_DAT,
        ST_MEM_REQUEST,
        ST_MEM_RESPONSE,
        ST_WAIT_ACCEPT
    } dport_state_e;

    localparam logic [3:0] REGION_CSR = 4'h0;
    localparam logic [3:0] REGION_REG = 4'h1;
    localparam logic [3:0] REGION_EXT = 4'hC;   // Non-standard extension

endpackage

//--- include/dbg_defines.svh
`ifndef DBG_DEFINES_SVH
`define DBG_DEFINES_SVH

// Data and address width, one word
`define DBG_XLEN 64

// Trace buffer depth is 2**DBG_STK_LOG2
`define DBG_STK_LOG2 3

// Debug memory size in bytes
`define DBG_MEM_BYTES 1024

// Cycles from memory acceptance to response
`define DBG_MEM_LAT 2

// Implemented CSRs at addresses 0 to DBG_CSR_NUM-1
`define DBG_CSR_NUM 8

`endif
